/* vec_accel_pkg.sv */
package vec_accel_pkg;

	// RAM and host bus word width
	localparam int data_width = 32;

	// One RAM word, seen as a single integer or as two 16-bit lanes
	typedef union packed {
		logic [data_width-1:0] full;
		struct packed {
			logic [data_width/2-1:0] hi;
			logic [data_width/2-1:0] lo;
		} lanes;
	} ram_word_t;

	// Element interpretation used by the engine
	typedef enum logic {
		add32   = 1'b0,
		add16x2 = 1'b1
	} op_mode_t;

	// Host register map
	localparam logic [2:0] reg_data  = 3'd0;
	localparam logic [2:0] reg_ptr   = 3'd1;
	localparam logic [2:0] reg_wen   = 3'd2;
	localparam logic [2:0] reg_id    = 3'd3;
	localparam logic [2:0] reg_src_a = 3'd4;
	localparam logic [2:0] reg_src_b = 3'd5;
	localparam logic [2:0] reg_dst   = 3'd6;
	localparam logic [2:0] reg_ctrl  = 3'd7;

	localparam logic [data_width-1:0] core_id = 32'h0000_0A11;

endpackage

/* dual_port_ram.sv */
`timescale 1ns/1ns

module dual_port_ram #(
	parameter int addr_width = 11
) (
	input  logic                                 clk,
	input  logic [vec_accel_pkg::data_width-1:0] data_a,
	input  logic [vec_accel_pkg::data_width-1:0] data_b,
	input  logic [addr_width-1:0]                addr_a,
	input  logic [addr_width-1:0]                addr_b,
	input  logic                                 we_a,
	input  logic                                 we_b,
	output logic [vec_accel_pkg::data_width-1:0] q_a,
	output logic [vec_accel_pkg::data_width-1:0] q_b
);
	import vec_accel_pkg::*;

	logic [data_width-1:0] mem [2**addr_width];

	// Both ports share one block so the array has a single driver
	always_ff @(posedge clk) begin
		if (we_a) begin
			mem[addr_a] <= data_a;
			q_a <= data_a;
		end else begin
			q_a <= mem[addr_a];
		end

		// Each port is write-first and sees its own write data
		if (we_b) begin
			mem[addr_b] <= data_b;
			q_b <= data_b;
		end else begin
			q_b <= mem[addr_b];
		end
	end

endmodule

/* host_window.sv */
`timescale 1ns/1ns

module host_window #(
	parameter int addr_width = 11
) (
	input  logic                                 clk,
	input  logic                                 rst,
	input  logic [2:0]                           address,
	input  logic                                 read,
	input  logic                                 write,
	input  logic [vec_accel_pkg::data_width-1:0] writedata,
	output logic [vec_accel_pkg::data_width-1:0] readdata,
	output logic [addr_width-1:0]                ram_addr,
	output logic [vec_accel_pkg::data_width-1:0] ram_wdata,
	output logic                                 ram_we,
	input  logic [vec_accel_pkg::data_width-1:0] ram_q,
	output logic                                 start,
	output logic [addr_width-1:0]                base_a,
	output logic [addr_width-1:0]                base_b,
	output logic [addr_width-1:0]                base_c,
	output logic [15:0]                          length,
	output vec_accel_pkg::op_mode_t              mode,
	input  logic                                 busy,
	output logic                                 done
);
	import vec_accel_pkg::*;

	logic [addr_width-1:0] ptr;
	logic                  wen;
	logic                  busy_q;
	logic                  data_wr;
	logic                  data_rd;
	logic                  ctrl_wr;

	assign data_wr = write && (address == reg_data);
	assign data_rd = read && (address == reg_data);
	assign ctrl_wr = write && (address == reg_ctrl);

	// Port A always looks at the pointer, so q_a tracks it one cycle later
	assign ram_addr  = ptr;
	assign ram_wdata = writedata;
	assign ram_we    = data_wr && wen;

	always_ff @(posedge clk) begin
		if (rst) begin
			ptr    <= '0;
			wen    <= 1'b1;
			start  <= 1'b0;
			busy_q <= 1'b0;
			done   <= 1'b0;
			base_a <= '0;
			base_b <= '0;
			base_c <= '0;
			length <= '0;
			mode   <= add32;
		end else begin
			busy_q <= busy;
			start  <= ctrl_wr && writedata[31] && !busy;

			// Data accesses step the pointer whether or not the RAM was written
			if (data_wr || data_rd)
				ptr <= ptr + 1'b1;

			if (write) begin
				case (address)
					reg_ptr:   ptr <= writedata[addr_width-1:0];
					reg_wen:   wen <= writedata[0];
					reg_src_a: base_a <= writedata[addr_width-1:0];
					reg_src_b: base_b <= writedata[addr_width-1:0];
					reg_dst:   base_c <= writedata[addr_width-1:0];
					reg_ctrl: begin
						if (!busy) begin
							length <= writedata[15:0];
							mode   <= op_mode_t'(writedata[16]);
						end
					end
					default: ;
				endcase
			end

			// Sticky until the next job is launched
			if (start)
				done <= 1'b0;
			else if (busy_q && !busy)
				done <= 1'b1;
		end
	end

	// Read data holds until the next read
	always_ff @(posedge clk) begin
		if (read) begin
			case (address)
				reg_data:  readdata <= ram_q;
				reg_ptr:   readdata <= data_width'(ptr);
				reg_wen:   readdata <= data_width'(wen);
				reg_id:    readdata <= core_id;
				reg_src_a: readdata <= data_width'(base_a);
				reg_src_b: readdata <= data_width'(base_b);
				reg_dst:   readdata <= data_width'(base_c);
				reg_ctrl:  readdata <= data_width'({done, busy});
				default:   readdata <= '0;
			endcase
		end
	end

endmodule

/* vector_engine.sv */
`timescale 1ns/1ns

module vector_engine #(
	parameter int addr_width = 11
) (
	input  logic                                 clk,
	input  logic                                 rst,
	input  logic                                 start,
	input  logic [addr_width-1:0]                base_a,
	input  logic [addr_width-1:0]                base_b,
	input  logic [addr_width-1:0]                base_c,
	input  logic [15:0]                          length,
	input  vec_accel_pkg::op_mode_t              mode,
	output logic                                 busy,
	output logic [addr_width-1:0]                ram_addr,
	output logic [vec_accel_pkg::data_width-1:0] ram_wdata,
	output logic                                 ram_we,
	input  logic [vec_accel_pkg::data_width-1:0] ram_q
);
	import vec_accel_pkg::*;

	localparam logic [1:0] s_idle = 2'd0;
	localparam logic [1:0] s_rd_a = 2'd1;
	localparam logic [1:0] s_rd_b = 2'd2;
	localparam logic [1:0] s_wr_c = 2'd3;

	logic [1:0]            state;
	logic [15:0]           idx;
	logic [15:0]           len_q;
	op_mode_t              mode_q;
	logic [addr_width-1:0] a_base_q;
	logic [addr_width-1:0] b_base_q;
	logic [addr_width-1:0] c_base_q;
	logic [addr_width-1:0] offset;
	ram_word_t             a_word;
	ram_word_t             b_word;
	ram_word_t             c_word;

	assign busy   = (state != s_idle);
	assign offset = addr_width'(idx);
	assign b_word = ram_q;

	// The finished check happens in s_rd_a, so length 0 is one busy cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= s_idle;
			idx   <= '0;
		end else begin
			case (state)
				s_idle: begin
					if (start) begin
						idx   <= '0;
						state <= s_rd_a;
					end
				end
				s_rd_a: begin
					if (idx == len_q)
						state <= s_idle;
					else
						state <= s_rd_b;
				end
				s_rd_b: state <= s_wr_c;
				s_wr_c: begin
					idx   <= idx + 16'd1;
					state <= s_rd_a;
				end
				default: state <= s_idle;
			endcase
		end
	end

	// Job parameters are captured once so the host may reprogram during a run
	always_ff @(posedge clk) begin
		if (state == s_idle && start) begin
			len_q    <= length;
			mode_q   <= mode;
			a_base_q <= base_a;
			b_base_q <= base_b;
			c_base_q <= base_c;
		end
	end

	// A arrives on q_b during s_rd_b, B during s_wr_c
	always_ff @(posedge clk) begin
		if (state == s_rd_b)
			a_word <= ram_q;
	end

	always_comb begin
		c_word.full = '0;
		case (mode_q)
			add16x2: begin
				// Lanes wrap on their own, nothing carries from lo into hi
				c_word.lanes.hi = a_word.lanes.hi + b_word.lanes.hi;
				c_word.lanes.lo = a_word.lanes.lo + b_word.lanes.lo;
			end
			default: c_word.full = a_word.full + b_word.full;
		endcase
	end

	always_comb begin
		case (state)
			s_rd_b:  ram_addr = b_base_q + offset;
			s_wr_c:  ram_addr = c_base_q + offset;
			default: ram_addr = a_base_q + offset;
		endcase
	end

	assign ram_we    = (state == s_wr_c);
	assign ram_wdata = c_word.full;

endmodule

/* vec_accel_top.sv */
`timescale 1ns/1ns

module vec_accel_top #(
	parameter int addr_width = 11
) (
	input  logic                                 clk,
	input  logic                                 rst,
	input  logic [2:0]                           address,
	input  logic                                 read,
	input  logic                                 write,
	input  logic [vec_accel_pkg::data_width-1:0] writedata,
	output logic [vec_accel_pkg::data_width-1:0] readdata,
	output logic                                 done
);
	import vec_accel_pkg::*;

	logic [addr_width-1:0] host_addr;
	logic [data_width-1:0] host_wdata;
	logic                  host_we;
	logic [data_width-1:0] host_q;
	logic [addr_width-1:0] eng_addr;
	logic [data_width-1:0] eng_wdata;
	logic                  eng_we;
	logic [data_width-1:0] eng_q;
	logic                  start;
	logic                  busy;
	logic [addr_width-1:0] base_a;
	logic [addr_width-1:0] base_b;
	logic [addr_width-1:0] base_c;
	logic [15:0]           length;
	op_mode_t              mode;

	host_window #(.addr_width(addr_width)) u_host (
		.clk(clk), .rst(rst), .address(address), .read(read), .write(write),
		.writedata(writedata), .readdata(readdata),
		.ram_addr(host_addr), .ram_wdata(host_wdata), .ram_we(host_we), .ram_q(host_q),
		.start(start), .base_a(base_a), .base_b(base_b), .base_c(base_c),
		.length(length), .mode(mode), .busy(busy), .done(done)
	);

	vector_engine #(.addr_width(addr_width)) u_engine (
		.clk(clk), .rst(rst), .start(start),
		.base_a(base_a), .base_b(base_b), .base_c(base_c),
		.length(length), .mode(mode), .busy(busy),
		.ram_addr(eng_addr), .ram_wdata(eng_wdata), .ram_we(eng_we), .ram_q(eng_q)
	);

	// Port A is the host side, port B the engine side
	dual_port_ram #(.addr_width(addr_width)) u_ram (
		.clk(clk),
		.data_a(host_wdata), .data_b(eng_wdata),
		.addr_a(host_addr), .addr_b(eng_addr),
		.we_a(host_we), .we_b(eng_we),
		.q_a(host_q), .q_b(eng_q)
	);

endmodule

/* vec_accel_assertions.sv */
`timescale 1ns/1ns

module vec_accel_assertions #(
	parameter bit engine_side = 1'b0
) (
	input logic                                 clk,
	input logic                                 rst,
	input logic                                 start,
	input logic                                 busy,
	input logic                                 read,
	input logic [vec_accel_pkg::data_width-1:0] readdata,
	input logic                                 ram_we
);

	generate
		if (engine_side) begin : g_engine
			// Port B only writes while a job is running
			we_inside_busy: assert property (@(posedge clk) disable iff (rst)
				!busy |-> !ram_we)
				else $error("RAM write enable seen outside a busy period");
		end else begin : g_host
			// A launch pulse never overlaps a running job
			start_while_idle: assert property (@(posedge clk) disable iff (rst)
				!(start && busy))
				else $error("start pulse seen while the engine is busy");

			// Read data only moves on a read strobe
			readdata_hold: assert property (@(posedge clk) disable iff (rst)
				(!read && !$isunknown(readdata)) |=> $stable(readdata))
				else $error("readdata changed without a read strobe");
		end
	endgenerate

endmodule

bind host_window vec_accel_assertions #(.engine_side(1'b0)) u_host_chk (
	.clk(clk), .rst(rst), .start(start), .busy(busy), .read(read),
	.readdata(readdata), .ram_we()
);

// Host writes on port A may come at any time, so the busy rule is for port B
bind vector_engine vec_accel_assertions #(.engine_side(1'b1)) u_engine_chk (
	.clk(clk), .rst(rst), .start(), .busy(busy), .read(),
	.readdata(), .ram_we(ram_we)
);

/* tb_vec_accel.sv */
`timescale 1ns/1ns

module tb_vec_accel;
	import vec_accel_pkg::*;

	localparam int addr_width = 11;
	localparam int depth = 2**addr_width;
	localparam logic [31:0] expected_id = 32'h0000_0A11;
	localparam int poll_limit = 100;

	logic        clk;
	logic        rst;
	logic [2:0]  address;
	logic        read;
	logic        write;
	logic [31:0] writedata;
	logic [31:0] readdata;
	logic        done;

	logic [31:0] lfsr_state;
	logic [31:0] model_mem [depth];
	int          model_ptr;
	logic        model_wen;
	int          checks;
	int          errors;
	logic        timed_out;

	vec_accel_top #(.addr_width(addr_width)) DUT (
		.clk(clk), .rst(rst), .address(address), .read(read), .write(write),
		.writedata(writedata), .readdata(readdata), .done(done)
	);

	always #4 clk = ~clk;

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			r = {r[30:0], lfsr_state[0]};
		end
		return r;
	endfunction

	function automatic logic [31:0] fill_word(input int a);
		return 32'hC0DE_0000 ^ (32'(a) << 16) ^ (32'(a) << 5) ^ 32'(a);
	endfunction

	task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t ns: %s, got %08h expected %08h", $time, what, got, exp);
		end
	endtask

	// The access is sampled on the second edge, the third edge leaves an idle cycle
	task automatic host_write(input logic [2:0] addr, input logic [31:0] data);
		@(posedge clk);
		address   <= addr;
		writedata <= data;
		write     <= 1'b1;
		@(posedge clk);
		write <= 1'b0;
	endtask

	task automatic host_read(input logic [2:0] addr, output logic [31:0] data);
		@(posedge clk);
		address <= addr;
		read    <= 1'b1;
		@(posedge clk);
		read <= 1'b0;
		@(posedge clk);
		data = readdata;
	endtask

	task automatic set_pointer(input int p);
		host_write(reg_ptr, 32'(p));
		model_ptr = p % depth;
	endtask

	task automatic write_data_word(input logic [31:0] data);
		host_write(reg_data, data);
		if (model_wen)
			model_mem[model_ptr] = data;
		model_ptr = (model_ptr + 1) % depth;
	endtask

	task automatic read_data_word(output logic [31:0] data);
		host_read(reg_data, data);
		model_ptr = (model_ptr + 1) % depth;
	endtask

	task automatic verify_ram(input string what);
		logic [31:0] v;
		set_pointer(0);
		for (int i = 0; i < depth; i++) begin
			read_data_word(v);
			check_word($sformatf("%s, RAM word %0d", what, i), v, model_mem[i]);
		end
	endtask

	// Elements are taken in order, as the engine does
	task automatic compute_model(input int a, input int b, input int c, input int len,
			input logic mode16);
		logic [31:0] wa;
		logic [31:0] wb;
		logic [15:0] hi;
		logic [15:0] lo;
		for (int i = 0; i < len; i++) begin
			wa = model_mem[(a + i) % depth];
			wb = model_mem[(b + i) % depth];
			if (mode16) begin
				hi = wa[31:16] + wb[31:16];
				lo = wa[15:0] + wb[15:0];
				model_mem[(c + i) % depth] = {hi, lo};
			end else begin
				model_mem[(c + i) % depth] = wa + wb;
			end
		end
	endtask

	task automatic start_job(input int a, input int b, input int c, input int len,
			input logic mode16);
		logic [31:0] v;
		host_write(reg_src_a, 32'(a));
		host_write(reg_src_b, 32'(b));
		host_write(reg_dst, 32'(c));
		host_write(reg_ctrl, 32'h8000_0000 | (32'(mode16) << 16) | 32'(len[15:0]));
		compute_model(a, b, c, len, mode16);
		// Busy set and done cleared right after the launch
		host_read(reg_ctrl, v);
		check_word("ctrl just after start", v, 32'h1);
	endtask

	task automatic wait_done();
		logic [31:0] v;
		int          polls;
		v = '0;
		polls = 0;
		while (!v[1] && polls < poll_limit) begin
			host_read(reg_ctrl, v);
			polls++;
		end
		if (!v[1]) begin
			$display("Timeout: the engine did not report done within %0d polls", poll_limit);
			timed_out = 1'b1;
		end else begin
			check_word("ctrl once done", v, 32'h2);
			check_word("done output once done", 32'(done), 32'h1);
		end
	endtask

	task automatic fill_array(input int base, input int len, input logic overflow_lanes);
		logic [31:0] w;
		set_pointer(base);
		for (int i = 0; i < len; i++) begin
			w = rand_bits(32);
			if (overflow_lanes)
				w = w | 32'h8000_8000;
			write_data_word(w);
		end
	endtask

	always @(posedge clk) begin
		if (timed_out) begin
			$display("checks: %0d, errors: %0d, engine timed out", checks, errors);
			$display("TEST FAILED");
			$finish;
		end
	end

	initial begin
		logic [31:0] v;
		int          p;
		int          n;
		int          a;
		int          b;
		int          c;
		clk        = 1'b0;
		rst        = 1'b1;
		address    = '0;
		read       = 1'b0;
		write      = 1'b0;
		writedata  = '0;
		lfsr_state = 32'd80822;
		model_ptr  = 0;
		model_wen  = 1'b1;
		checks     = 0;
		errors     = 0;
		timed_out  = 1'b0;
		repeat (3) @(posedge clk);
		rst <= 1'b0;

		host_read(reg_ctrl, v);
		check_word("ctrl after reset", v, 32'h0);
		check_word("done output after reset", 32'(done), 32'h0);
		host_read(reg_wen, v);
		check_word("wen after reset", v, 32'h1);
		host_read(reg_id, v);
		check_word("ID register", v, expected_id);

		// Known contents everywhere so untouched words can be compared
		set_pointer(0);
		for (int i = 0; i < depth; i++)
			write_data_word(fill_word(i));

		p = int'(rand_bits(addr_width));
		n = 1 + int'(rand_bits(4));
		fill_array(p, n, 1'b0);
		host_read(reg_ptr, v);
		check_word("pointer after burst write", v, 32'((p + n) % depth));
		set_pointer(p);
		for (int i = 0; i < n; i++) begin
			read_data_word(v);
			check_word($sformatf("burst readback %0d", i), v, model_mem[(p + i) % depth]);
		end
		host_read(reg_ptr, v);
		check_word("pointer after burst readback", v, 32'(model_ptr));

		host_write(reg_wen, 32'h0);
		model_wen = 1'b0;
		host_read(reg_wen, v);
		check_word("wen cleared", v, 32'h0);
		p = int'(rand_bits(addr_width));
		n = 1 + int'(rand_bits(3));
		fill_array(p, n, 1'b0);
		host_read(reg_ptr, v);
		check_word("pointer after masked writes", v, 32'((p + n) % depth));
		host_write(reg_wen, 32'h1);
		model_wen = 1'b1;
		set_pointer(p);
		for (int i = 0; i < n; i++) begin
			read_data_word(v);
			check_word($sformatf("masked write readback %0d", i), v, model_mem[(p + i) % depth]);
		end

		a = int'(rand_bits(9));
		b = 512 + int'(rand_bits(9));
		c = 1024 + int'(rand_bits(9));
		n = 1 + int'(rand_bits(6) % 40);
		fill_array(a, n, 1'b0);
		fill_array(b, n, 1'b0);
		start_job(a, b, c, n, 1'b0);
		wait_done();
		verify_ram("add32 job");

		a = int'(rand_bits(9));
		b = 512 + int'(rand_bits(9));
		c = 1024 + int'(rand_bits(9));
		n = 1 + int'(rand_bits(4));
		fill_array(a, n, 1'b1);
		fill_array(b, n, 1'b1);
		start_job(a, b, c, n, 1'b1);
		wait_done();
		verify_ram("add16x2 job");

		start_job(a, b, c, 0, 1'b0);
		wait_done();
		verify_ram("length 0 job");
		start_job(a, b, c, 4, 1'b0);
		wait_done();
		verify_ram("job after length 0");

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

/* vec_accel.f */
vec_accel_pkg.sv
dual_port_ram.sv
host_window.sv
vector_engine.sv
vec_accel_top.sv
vec_accel_assertions.sv
tb_vec_accel.sv

/* run_sim.sh */
#!/bin/sh
# Builds the vec_accel testbench with Verilator and runs it.
# Exits nonzero unless the simulation reports a pass.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_vec_accel \
	-f vec_accel.f \
	-o sim_vec_accel
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/sim_vec_accel)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "TEST OK"; then
	exit 0
fi
echo "Pass message not found"
exit 1
